// ==== rtl/alu.sv ====
// two-operand alu with add, subtract, compare, logic, move and signed-amount shift.
`timescale 1ns/1ns
`default_nettype none

module alu
(
	input logic [crPkg::WORD_W-1:0] a,
	input logic [crPkg::WORD_W-1:0] operandB,
	input logic useImm,
	input logic [crPkg::WORD_W-1:0] imm,
	input logic carryIn,
	input crPkg::aluOpE aluOp,
	output logic [crPkg::WORD_W-1:0] aluResult,
	output logic [crPkg::FLAG_W-1:0] aluFlags
);

	localparam int MSB = crPkg::WORD_W - 1;

	// second operand after the immediate mux.
	logic [crPkg::WORD_W-1:0] b;

	// 17-bit carry paths.
	logic addCarry;
	logic [crPkg::WORD_W:0] sum;
	logic [crPkg::WORD_W:0] diff;
	logic sumOvf;
	logic diffOvf;

	// shift amount handling.
	logic [crPkg::SHAMT_W-1:0] shField;
	logic [crPkg::SHAMT_W-1:0] shMag;
	logic shNeg;
	logic [crPkg::WORD_W-1:0] shiftOut;

	assign b = useImm ? imm : operandB;

	// only addc consumes the stored carry.
	assign addCarry = (aluOp == crPkg::ALU_ADDC) ? carryIn : 1'b0;

	assign sum = {1'b0, a} + {1'b0, b} + {{crPkg::WORD_W{1'b0}}, addCarry};
	// top bit of the difference is the borrow that is set when a < b unsigned.
	assign diff = {1'b0, a} - {1'b0, b};

	// overflow when both operands share a sign and the result sign differs.
	assign sumOvf = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
	// for subtraction the operand signs must differ.
	assign diffOvf = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);

	// low five bits of b are a signed amount.
	assign shField = b[crPkg::SHAMT_W-1:0];
	assign shNeg = shField[crPkg::SHAMT_W-1];
	// the magnitude of -16 comes out as 16 and clears the word.
	assign shMag = shNeg ? -shField : shField;
	// negative amount means logical right shift.
	assign shiftOut = shNeg ? (a >> shMag) : (a << shMag);

	// result mux.
	always_comb
	begin
		case (aluOp)
		crPkg::ALU_ADD,
		crPkg::ALU_ADDU,
		crPkg::ALU_ADDC: aluResult = sum[MSB:0];
		crPkg::ALU_SUB: aluResult = diff[MSB:0];
		// compares produce no data.
		crPkg::ALU_CMP: aluResult = '0;
		crPkg::ALU_AND: aluResult = a & b;
		crPkg::ALU_OR: aluResult = a | b;
		crPkg::ALU_XOR: aluResult = a ^ b;
		crPkg::ALU_MOV: aluResult = b;
		crPkg::ALU_LSH: aluResult = shiftOut;
		default: aluResult = '0;
		endcase
	end

	// candidate flags of which the writeback stage keeps only the owned bits.
	always_comb
	begin
		aluFlags = '0;
		// full 16-bit equality.
		aluFlags[crPkg::FLAG_Z] = (a == b);
		aluFlags[crPkg::FLAG_C] = (aluOp == crPkg::ALU_SUB) ? diff[crPkg::WORD_W] :
			sum[crPkg::WORD_W];
		aluFlags[crPkg::FLAG_F] = (aluOp == crPkg::ALU_SUB) ? diffOvf : sumOvf;
		aluFlags[crPkg::FLAG_N] = ($signed(a) < $signed(b));
		aluFlags[crPkg::FLAG_L] = (a < b);
	end

endmodule

`default_nettype wire

// ==== rtl/crPkg.sv ====
// shared widths, opcode field codes, flag bit positions and the alu operation enum.
`default_nettype none

package crPkg;

	// data word width of the datapath.
	localparam int WORD_W = 16;

	// register number width and register count.
	localparam int REG_ADDR_W = 4;
	localparam int NUM_REGS = 1 << REG_ADDR_W;

	// width of the signed shift amount field.
	localparam int SHAMT_W = 5;

	// status flag vector width.
	localparam int FLAG_W = 5;

	// flag bit positions inside the status register.
	// z is set on equal compare.
	localparam int FLAG_Z = 4;
	// c is carry out of a sum, or borrow of a subtraction.
	localparam int FLAG_C = 3;
	// f is signed overflow.
	localparam int FLAG_F = 2;
	// n is signed less-than.
	localparam int FLAG_N = 1;
	// l is unsigned less-than.
	localparam int FLAG_L = 0;

	// high field classes, instruction bits 15..12.
	localparam logic [3:0] OP_REG = 4'b0000;
	localparam logic [3:0] OP_SHIFT = 4'b1000;

	// extension field codes, instruction bits 7..4.
	// an immediate form uses the same code in the high field.
	localparam logic [3:0] EXT_AND = 4'b0001;
	localparam logic [3:0] EXT_OR = 4'b0010;
	localparam logic [3:0] EXT_XOR = 4'b0011;
	localparam logic [3:0] EXT_LSH = 4'b0100;
	localparam logic [3:0] EXT_ADD = 4'b0101;
	localparam logic [3:0] EXT_ADDU = 4'b0110;
	localparam logic [3:0] EXT_ADDC = 4'b0111;
	localparam logic [3:0] EXT_SUB = 4'b1001;
	localparam logic [3:0] EXT_CMP = 4'b1011;
	localparam logic [3:0] EXT_MOV = 4'b1101;

	// alu operations, register and immediate forms share one value.
	typedef enum logic [3:0]
	{
		ALU_ADD,
		ALU_ADDU,
		ALU_ADDC,
		ALU_SUB,
		ALU_CMP,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_MOV,
		ALU_LSH
	} aluOpE;

endpackage

`default_nettype wire

// ==== rtl/datapathTop.sv ====
// execute datapath top level joining decoder, register file, alu and writeback stage.
`timescale 1ns/1ns
`default_nettype none

module datapathTop
(
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input logic [crPkg::WORD_W-1:0] instr,
	output logic resultValid,
	output logic [crPkg::WORD_W-1:0] result,
	output logic [crPkg::REG_ADDR_W-1:0] resultReg,
	output logic [crPkg::FLAG_W-1:0] flags
);

	// decoder outputs.
	logic opValid;
	crPkg::aluOpE aluOp;
	logic [crPkg::REG_ADDR_W-1:0] destReg;
	logic [crPkg::REG_ADDR_W-1:0] srcReg;
	logic [crPkg::WORD_W-1:0] imm;
	logic useImm;
	logic regWrite;

	// register reads and alu outputs.
	logic [crPkg::WORD_W-1:0] readDataA;
	logic [crPkg::WORD_W-1:0] readDataB;
	logic [crPkg::WORD_W-1:0] aluResult;
	logic [crPkg::FLAG_W-1:0] aluFlags;

	instrDecoder decoder0
	(
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.opValid(opValid),
		.aluOp(aluOp),
		.destReg(destReg),
		.srcReg(srcReg),
		.imm(imm),
		.useImm(useImm),
		.regWrite(regWrite)
	);

	// rdest is both operand a and the write target.
	regFile regFile0
	(
		.clk(clk),
		.rstN(rstN),
		.readAddrA(destReg),
		.readAddrB(srcReg),
		.writeEn(regWrite),
		.writeAddr(destReg),
		.writeData(aluResult),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	// stored carry feeds addc.
	alu alu0
	(
		.a(readDataA),
		.operandB(readDataB),
		.useImm(useImm),
		.imm(imm),
		.carryIn(flags[crPkg::FLAG_C]),
		.aluOp(aluOp),
		.aluResult(aluResult),
		.aluFlags(aluFlags)
	);

	writebackStage writeback0
	(
		.clk(clk),
		.rstN(rstN),
		.opValid(opValid),
		.aluOp(aluOp),
		.destReg(destReg),
		.aluResult(aluResult),
		.aluFlags(aluFlags),
		.resultValid(resultValid),
		.result(result),
		.resultReg(resultReg),
		.flags(flags)
	);

endmodule

`default_nettype wire

// ==== rtl/instrDecoder.sv ====
// instruction decoder with registered operation, register numbers, immediate and write enable.
`timescale 1ns/1ns
`default_nettype none

module instrDecoder
(
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input logic [crPkg::WORD_W-1:0] instr,
	output logic opValid,
	output crPkg::aluOpE aluOp,
	output logic [crPkg::REG_ADDR_W-1:0] destReg,
	output logic [crPkg::REG_ADDR_W-1:0] srcReg,
	output logic [crPkg::WORD_W-1:0] imm,
	output logic useImm,
	output logic regWrite
);

	// instruction fields.
	logic [3:0] hiField;
	logic [3:0] extField;

	// the three immediate extensions.
	logic [crPkg::WORD_W-1:0] immSext;
	logic [crPkg::WORD_W-1:0] immZext;
	logic [crPkg::WORD_W-1:0] shImm;

	// decode results before the register.
	crPkg::aluOpE decOp;
	logic [crPkg::WORD_W-1:0] decImm;
	logic decUseImm;
	logic decKnown;
	logic decWrite;

	assign hiField = instr[15:12];
	assign extField = instr[7:4];

	// 8-bit immediate, signed or unsigned.
	assign immSext = {{(crPkg::WORD_W-8){instr[7]}}, instr[7:0]};
	assign immZext = {{(crPkg::WORD_W-8){1'b0}}, instr[7:0]};
	// lshi carries a signed five-bit amount in bits 4..0.
	assign shImm = {{(crPkg::WORD_W-crPkg::SHAMT_W){instr[crPkg::SHAMT_W-1]}},
		instr[crPkg::SHAMT_W-1:0]};

	// decode table.
	always_comb
	begin
		decOp = crPkg::ALU_MOV;
		decImm = immZext;
		decUseImm = 1'b0;
		decKnown = 1'b1;
		if (hiField == crPkg::OP_REG)
		begin
			// register class, extension picks the operation.
			case (extField)
			crPkg::EXT_AND: decOp = crPkg::ALU_AND;
			crPkg::EXT_OR: decOp = crPkg::ALU_OR;
			crPkg::EXT_XOR: decOp = crPkg::ALU_XOR;
			crPkg::EXT_ADD: decOp = crPkg::ALU_ADD;
			crPkg::EXT_ADDU: decOp = crPkg::ALU_ADDU;
			crPkg::EXT_ADDC: decOp = crPkg::ALU_ADDC;
			crPkg::EXT_SUB: decOp = crPkg::ALU_SUB;
			crPkg::EXT_CMP: decOp = crPkg::ALU_CMP;
			crPkg::EXT_MOV: decOp = crPkg::ALU_MOV;
			default: decKnown = 1'b0;
			endcase
		end
		else if (hiField == crPkg::OP_SHIFT)
		begin
			decOp = crPkg::ALU_LSH;
			if (extField == crPkg::EXT_LSH)
				decUseImm = 1'b0;
			else if (instr[7:5] == 3'b000)
			begin
				// lshi, amount comes from the word itself.
				decUseImm = 1'b1;
				decImm = shImm;
			end
			else
				decKnown = 1'b0;
		end
		else
		begin
			// immediate class, high field holds the extension code.
			decUseImm = 1'b1;
			case (hiField)
			crPkg::EXT_AND: decOp = crPkg::ALU_AND;
			crPkg::EXT_OR: decOp = crPkg::ALU_OR;
			crPkg::EXT_XOR: decOp = crPkg::ALU_XOR;
			crPkg::EXT_ADDU: decOp = crPkg::ALU_ADDU;
			crPkg::EXT_ADD:
			begin
				decOp = crPkg::ALU_ADD;
				decImm = immSext;
			end
			crPkg::EXT_ADDC:
			begin
				decOp = crPkg::ALU_ADDC;
				decImm = immSext;
			end
			crPkg::EXT_SUB:
			begin
				decOp = crPkg::ALU_SUB;
				decImm = immSext;
			end
			crPkg::EXT_CMP:
			begin
				decOp = crPkg::ALU_CMP;
				decImm = immSext;
			end
			crPkg::EXT_MOV:
			begin
				decOp = crPkg::ALU_MOV;
				decImm = immSext;
			end
			default: decKnown = 1'b0;
			endcase
		end
	end

	// compares only touch flags.
	assign decWrite = decKnown && (decOp != crPkg::ALU_CMP);

	// control bits, unrecognized words never get through.
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			opValid <= 1'b0;
			regWrite <= 1'b0;
		end
		else
		begin
			opValid <= instrValid && decKnown;
			regWrite <= instrValid && decWrite;
		end
	end

	// payload fields, loaded with each strobe.
	always_ff @(posedge clk)
	begin
		if (instrValid)
		begin
			aluOp <= decOp;
			destReg <= instr[11:8];
			srcReg <= instr[3:0];
			imm <= decImm;
			useImm <= decUseImm;
		end
	end

	// a register write always belongs to a valid operation.
	writeNeedsValid: assert property (@(posedge clk) disable iff (!rstN)
		regWrite |-> opValid);

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
// sixteen-entry register file with two combinational reads and one synchronous write.
`timescale 1ns/1ns
`default_nettype none

module regFile
(
	input logic clk,
	input logic rstN,
	input logic [crPkg::REG_ADDR_W-1:0] readAddrA,
	input logic [crPkg::REG_ADDR_W-1:0] readAddrB,
	input logic writeEn,
	input logic [crPkg::REG_ADDR_W-1:0] writeAddr,
	input logic [crPkg::WORD_W-1:0] writeData,
	output logic [crPkg::WORD_W-1:0] readDataA,
	output logic [crPkg::WORD_W-1:0] readDataB
);

	// register storage.
	logic [crPkg::WORD_W-1:0] regs [crPkg::NUM_REGS];

	// all registers start at zero.
	// the write lands on the edge after decode, so the next op reads it.
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < crPkg::NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (writeEn)
			regs[writeAddr] <= writeData;
	end

	// port a reads rdest, port b reads rsrc.
	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

endmodule

`default_nettype wire

// ==== rtl/writebackStage.sv ====
// writeback stage with result register, valid pulse and the status flag register.
`timescale 1ns/1ns
`default_nettype none

module writebackStage
(
	input logic clk,
	input logic rstN,
	input logic opValid,
	input crPkg::aluOpE aluOp,
	input logic [crPkg::REG_ADDR_W-1:0] destReg,
	input logic [crPkg::WORD_W-1:0] aluResult,
	input logic [crPkg::FLAG_W-1:0] aluFlags,
	output logic resultValid,
	output logic [crPkg::WORD_W-1:0] result,
	output logic [crPkg::REG_ADDR_W-1:0] resultReg,
	output logic [crPkg::FLAG_W-1:0] flags
);

	// flag bits owned by the current operation.
	logic [crPkg::FLAG_W-1:0] ownMask;

	// arithmetic owns c and f, compares own z, n and l.
	always_comb
	begin
		ownMask = '0;
		case (aluOp)
		crPkg::ALU_ADD,
		crPkg::ALU_ADDU,
		crPkg::ALU_ADDC,
		crPkg::ALU_SUB:
		begin
			ownMask[crPkg::FLAG_C] = 1'b1;
			ownMask[crPkg::FLAG_F] = 1'b1;
		end
		crPkg::ALU_CMP:
		begin
			ownMask[crPkg::FLAG_Z] = 1'b1;
			ownMask[crPkg::FLAG_N] = 1'b1;
			ownMask[crPkg::FLAG_L] = 1'b1;
		end
		// logic, move and shift keep every flag.
		default: ownMask = '0;
		endcase
	end

	// valid pulse and status register.
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			resultValid <= 1'b0;
			flags <= '0;
		end
		else
		begin
			resultValid <= opValid;
			if (opValid)
				flags <= (flags & ~ownMask) | (aluFlags & ownMask);
		end
	end

	// result payload.
	always_ff @(posedge clk)
	begin
		if (opValid)
		begin
			result <= aluResult;
			resultReg <= destReg;
		end
	end

	// no stray result straight out of reset.
	quietAfterReset: assert property (@(posedge clk) !rstN |=> !resultValid);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build the datapath testbench with Verilator, run it and check the log.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=./obj_dir/VtbDatapath

if ! verilator --binary --timing --assert -j 0 --top-module tbDatapath -f sim.f; then
	echo "verilator build failed"
	exit 1
fi

if [ ! -x "$BIN" ]; then
	echo "simulation binary $BIN is missing"
	exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# The testbench prints the pass message on a line of its own.
if grep -qx "TESTS PASSED" "$LOG"; then
	echo "run.sh: simulation passed"
	exit 0
fi

echo "run.sh: simulation failed, see $LOG"
exit 1

// ==== sim.f ====
rtl/crPkg.sv
rtl/instrDecoder.sv
rtl/regFile.sv
rtl/alu.sv
rtl/writebackStage.sv
rtl/datapathTop.sv
test/tbDatapath.sv

// ==== test/tbDatapath.sv ====
// datapath testbench with clock, reset, reference model, directed and random stimulus and checks.
`timescale 1ns/1ns
`default_nettype none

module tbDatapath;

	logic clk;
	logic rstN;
	logic instrValid;
	logic [crPkg::WORD_W-1:0] instr;
	logic resultValid;
	logic [crPkg::WORD_W-1:0] result;
	logic [crPkg::REG_ADDR_W-1:0] resultReg;
	logic [crPkg::FLAG_W-1:0] flags;

	// reference model state.
	logic [crPkg::WORD_W-1:0] mRegs [crPkg::NUM_REGS];
	logic [crPkg::FLAG_W-1:0] mFlags;

	// expected results in issue order with the cycle each one is due.
	logic [crPkg::WORD_W-1:0] expResult [1024];
	logic [crPkg::REG_ADDR_W-1:0] expReg [1024];
	logic [crPkg::FLAG_W-1:0] expFlags [1024];
	int expDue [1024];
	logic [9:0] rdIdx;
	logic [9:0] wrIdx;
	logic pending;

	int cycleCnt;
	logic started;
	int errCount;
	int timeoutCount;
	integer seed;
	logic [crPkg::WORD_W-1:0] word;

	datapathTop dut0
	(
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.resultValid(resultValid),
		.result(result),
		.resultReg(resultReg),
		.flags(flags)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	assign pending = (rdIdx != wrIdx);

	// cycle count and queue pop settle before the next edge.
	always @(posedge clk)
	begin
		cycleCnt <= cycleCnt + 1;
		if (resultValid && pending)
			rdIdx <= rdIdx + 10'd1;
	end

	// nothing comes out of reset and flags stay clear until the first instruction.
	resetValid: assert property (@(posedge clk) (cycleCnt >= 1 && !started) |-> !resultValid)
		else
		begin
			errCount++;
			$display("FAILED t=%0t resultValid got %b expected 0", $time, $sampled(resultValid));
		end
	resetFlags: assert property (@(posedge clk) (cycleCnt >= 1 && !started) |-> flags == '0)
		else
		begin
			errCount++;
			$display("FAILED t=%0t flags got %b expected 00000", $time, $sampled(flags));
		end

	// every pulse belongs to an outstanding recognized word.
	noOrphan: assert property (@(posedge clk) disable iff (!rstN) resultValid |-> pending)
		else
		begin
			errCount++;
			$display("t=%0t resultValid pulsed with no instruction outstanding", $time);
		end

	// the result is due two edges after the strobe and neither early nor late.
	onTime: assert property (@(posedge clk) disable iff (!rstN)
		(resultValid && pending) |-> cycleCnt == expDue[rdIdx])
		else
		begin
			errCount++;
			$display("FAILED t=%0t resultValid cycle got %0d expected %0d", $time,
				$sampled(cycleCnt), expDue[$sampled(rdIdx)]);
		end
	notLate: assert property (@(posedge clk) disable iff (!rstN)
		(pending && cycleCnt == expDue[rdIdx]) |-> resultValid)
		else
		begin
			errCount++;
			$display("t=%0t no resultValid for the instruction due in this cycle", $time);
		end

	resultOk: assert property (@(posedge clk) disable iff (!rstN)
		(resultValid && pending) |-> result == expResult[rdIdx])
		else
		begin
			errCount++;
			$display("FAILED t=%0t result got %h expected %h", $time, $sampled(result),
				expResult[$sampled(rdIdx)]);
		end
	regOk: assert property (@(posedge clk) disable iff (!rstN)
		(resultValid && pending) |-> resultReg == expReg[rdIdx])
		else
		begin
			errCount++;
			$display("FAILED t=%0t resultReg got %0d expected %0d", $time, $sampled(resultReg),
				expReg[$sampled(rdIdx)]);
		end
	flagsOk: assert property (@(posedge clk) disable iff (!rstN)
		(resultValid && pending) |-> flags == expFlags[rdIdx])
		else
		begin
			errCount++;
			$display("FAILED t=%0t flags got %b expected %b", $time, $sampled(flags),
				expFlags[$sampled(rdIdx)]);
		end

	// word builders for the three instruction forms.
	function automatic logic [15:0] regWord(input logic [3:0] ext, input logic [3:0] rd,
		input logic [3:0] rs);
		return {crPkg::OP_REG, rd, ext, rs};
	endfunction

	function automatic logic [15:0] immWord(input logic [3:0] code, input logic [3:0] rd,
		input logic [7:0] imm8);
		return {code, rd, imm8};
	endfunction

	function automatic logic [15:0] shiftWord(input logic [3:0] rd, input logic [4:0] amt);
		return {crPkg::OP_SHIFT, rd, 3'b000, amt};
	endfunction

	// the nine codes of the register class.
	function automatic logic isRegClassCode(input logic [3:0] code);
		case (code)
		crPkg::EXT_AND, crPkg::EXT_OR, crPkg::EXT_XOR,
		crPkg::EXT_ADD, crPkg::EXT_ADDU, crPkg::EXT_ADDC,
		crPkg::EXT_SUB, crPkg::EXT_CMP, crPkg::EXT_MOV: return 1'b1;
		default: return 1'b0;
		endcase
	endfunction

	// executes one word on the model and queues the outcome of a recognized one.
	task automatic modelWord(input logic [15:0] w);
		logic [3:0] op;
		logic [3:0] rd;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		logic known;
		logic carry;
		int usum;
		int sa;
		int sb;
		int sr;
		int amt;
		rd = w[11:8];
		op = w[7:4];
		a = mRegs[rd];
		b = mRegs[w[3:0]];
		known = 1'b1;
		res = 16'h0000;
		if (w[15:12] == crPkg::OP_REG)
			known = isRegClassCode(op);
		else if (w[15:12] == crPkg::OP_SHIFT)
		begin
			if (op != crPkg::EXT_LSH)
			begin
				// lshi takes a signed amount from bits 4..0.
				known = (w[7:5] == 3'b000);
				b = {{11{w[4]}}, w[4:0]};
			end
			op = crPkg::EXT_LSH;
		end
		else
		begin
			op = w[15:12];
			known = isRegClassCode(op);
			if (op == crPkg::EXT_ADDU || op == crPkg::EXT_AND || op == crPkg::EXT_OR ||
				op == crPkg::EXT_XOR)
				b = {8'h00, w[7:0]};
			else
				b = {{8{w[7]}}, w[7:0]};
		end
		if (!known)
			return;
		sa = int'($signed(a));
		sb = int'($signed(b));
		case (op)
		crPkg::EXT_ADD, crPkg::EXT_ADDU, crPkg::EXT_ADDC:
		begin
			carry = (op == crPkg::EXT_ADDC) ? mFlags[crPkg::FLAG_C] : 1'b0;
			// unsigned integer sum, anything above 16 bits is the carry.
			usum = int'(a) + int'(b) + int'(carry);
			res = usum[15:0];
			sr = sa + sb + int'(carry);
			mFlags[crPkg::FLAG_C] = (usum > 65535);
			mFlags[crPkg::FLAG_F] = (sr > 32767) || (sr < -32768);
		end
		crPkg::EXT_SUB:
		begin
			res = a - b;
			sr = sa - sb;
			mFlags[crPkg::FLAG_C] = (a < b);
			mFlags[crPkg::FLAG_F] = (sr > 32767) || (sr < -32768);
		end
		crPkg::EXT_CMP:
		begin
			mFlags[crPkg::FLAG_Z] = (a == b);
			mFlags[crPkg::FLAG_N] = (sa < sb);
			mFlags[crPkg::FLAG_L] = (a < b);
		end
		crPkg::EXT_AND: res = a & b;
		crPkg::EXT_OR: res = a | b;
		crPkg::EXT_XOR: res = a ^ b;
		crPkg::EXT_MOV: res = b;
		default:
		begin
			// a positive amount shifts left and a negative one shifts logically right.
			amt = int'($signed(b[4:0]));
			if (amt >= 0)
				res = a << amt;
			else
				res = a >> (-amt);
		end
		endcase
		if (op != crPkg::EXT_CMP)
			mRegs[rd] = res;
		expResult[wrIdx] <= res;
		expReg[wrIdx] <= rd;
		expFlags[wrIdx] <= mFlags;
		expDue[wrIdx] <= cycleCnt + 3;
		wrIdx <= wrIdx + 10'd1;
	endtask

	// one strobe with its word on the next edge.
	task automatic issue(input logic [15:0] w);
		@(posedge clk);
		instrValid <= 1'b1;
		instr <= w;
		started <= 1'b1;
		modelWord(w);
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			@(posedge clk);
			instrValid <= 1'b0;
		end
	endtask

	// stop issuing and wait until every expected result has been seen.
	task automatic drain(input int limit);
		idle(1);
		for (int i = 0; i < limit && pending; i++)
			@(posedge clk);
		if (pending)
		begin
			timeoutCount++;
			$display("t=%0t timeout, %0d results never arrived", $time, wrIdx - rdIdx);
		end
	endtask

	initial
	begin
		seed = 32'hc5d;
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		mFlags = '0;
		for (int i = 0; i < crPkg::NUM_REGS; i++)
			mRegs[i] = '0;
		rdIdx = '0;
		wrIdx = '0;
		cycleCnt = 0;
		started = 1'b0;
		errCount = 0;
		timeoutCount = 0;
		repeat (5) @(posedge clk);
		rstN <= 1'b1;
		idle(3);

		// immediate loads followed by register and immediate arithmetic and moves.
		issue(immWord(crPkg::EXT_MOV, 4'd1, 8'h05));
		issue(immWord(crPkg::EXT_MOV, 4'd2, 8'hF0));
		issue(immWord(crPkg::EXT_MOV, 4'd3, 8'h7F));
		idle(1);
		issue(regWord(crPkg::EXT_ADD, 4'd1, 4'd2));
		issue(immWord(crPkg::EXT_ADD, 4'd3, 8'h81));
		issue(immWord(crPkg::EXT_ADDU, 4'd1, 8'hFF));
		issue(regWord(crPkg::EXT_ADDU, 4'd2, 4'd3));
		issue(regWord(crPkg::EXT_SUB, 4'd2, 4'd1));
		issue(immWord(crPkg::EXT_SUB, 4'd3, 8'h10));
		issue(regWord(crPkg::EXT_MOV, 4'd4, 4'd3));
		issue(immWord(crPkg::EXT_MOV, 4'd5, 8'h80));
		drain(20);

		// carry, overflow, addc chain, borrow and compares.
		issue(immWord(crPkg::EXT_MOV, 4'd6, 8'hFF));
		issue(immWord(crPkg::EXT_ADD, 4'd6, 8'h01));
		issue(immWord(crPkg::EXT_MOV, 4'd7, 8'h7F));
		issue(shiftWord(4'd7, 5'd8));
		issue(immWord(crPkg::EXT_OR, 4'd7, 8'hFF));
		issue(immWord(crPkg::EXT_ADD, 4'd7, 8'h01));
		issue(immWord(crPkg::EXT_MOV, 4'd9, 8'hFF));
		issue(regWord(crPkg::EXT_ADD, 4'd9, 4'd9));
		issue(regWord(crPkg::EXT_ADDC, 4'd10, 4'd0));
		issue(immWord(crPkg::EXT_ADDC, 4'd10, 8'h7F));
		issue(immWord(crPkg::EXT_MOV, 4'd11, 8'h03));
		issue(immWord(crPkg::EXT_SUB, 4'd11, 8'h05));
		issue(immWord(crPkg::EXT_MOV, 4'd12, 8'h80));
		issue(shiftWord(4'd12, 5'd8));
		issue(immWord(crPkg::EXT_SUB, 4'd12, 8'h01));
		issue(immWord(crPkg::EXT_MOV, 4'd1, 8'h10));
		issue(regWord(crPkg::EXT_CMP, 4'd1, 4'd1));
		issue(immWord(crPkg::EXT_CMP, 4'd11, 8'h7F));
		issue(regWord(crPkg::EXT_CMP, 4'd1, 4'd11));
		issue(immWord(crPkg::EXT_ADD, 4'd1, 8'h00));
		drain(20);

		// logic, zero-extended immediates and both shift forms.
		issue(regWord(crPkg::EXT_AND, 4'd1, 4'd2));
		issue(regWord(crPkg::EXT_OR, 4'd3, 4'd4));
		issue(regWord(crPkg::EXT_XOR, 4'd5, 4'd5));
		issue(immWord(crPkg::EXT_AND, 4'd2, 8'hF0));
		issue(immWord(crPkg::EXT_OR, 4'd5, 8'h81));
		issue(immWord(crPkg::EXT_XOR, 4'd3, 8'hFF));
		issue(immWord(crPkg::EXT_MOV, 4'd13, 8'h03));
		issue(regWord(crPkg::EXT_LSH, 4'd1, 4'd13) | 16'h8000);
		issue(immWord(crPkg::EXT_MOV, 4'd14, 8'hFC));
		issue({crPkg::OP_SHIFT, 4'd2, crPkg::EXT_LSH, 4'd14});
		issue(shiftWord(4'd3, 5'd5));
		issue(shiftWord(4'd4, 5'h1C));
		issue(shiftWord(4'd6, 5'h10));
		drain(20);

		// dependent back-to-back words mixed with unrecognized ones.
		issue(immWord(crPkg::EXT_MOV, 4'd1, 8'h01));
		issue(regWord(crPkg::EXT_ADD, 4'd1, 4'd1));
		issue(16'hF123);
		issue(regWord(crPkg::EXT_ADD, 4'd1, 4'd1));
		issue(immWord(crPkg::EXT_MOV, 4'd2, 8'hFF));
		issue(16'h0081);
		issue(immWord(crPkg::EXT_ADD, 4'd2, 8'h01));
		issue(regWord(crPkg::EXT_ADDC, 4'd1, 4'd2));
		issue(16'h8A2F);
		issue(immWord(crPkg::EXT_ADDC, 4'd1, 8'h7F));
		issue(16'h4123);
		issue(regWord(crPkg::EXT_SUB, 4'd1, 4'd2));
		issue(regWord(crPkg::EXT_CMP, 4'd1, 4'd2));
		drain(20);

		// random words with idle gaps where many of them are not recognized.
		for (int i = 0; i < 200; i++)
		begin
			word = 16'($random(seed));
			issue(word);
			if (($random(seed) & 3) == 0)
				idle(1);
		end
		drain(20);
		idle(4);

		$display("errors: %0d failed checks, %0d timeouts", errCount, timeoutCount);
		if (errCount == 0 && timeoutCount == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
